// ==== logic/rooth_config.svh ====
/*
 * Core configuration for the execute stage
 * Data width, product width, shift-amount width and operation code width
 */

`ifndef ROOTH_CONFIG_SVH
`define ROOTH_CONFIG_SVH

// Data word and full product
`define CPU_WIDTH        32
`define CPU_DOUBLE_WIDTH 64

// Low bits of src2 that a shift uses
`define SHAMT_WIDTH      5

`define ALU_OP_WIDTH     5

`endif

// ==== logic/rooth_pkg.sv ====
/*
 * Shared types of the execute stage
 * Operation codes, the issued request and the result with its branch flags
 */

`include "rooth_config.svh"

package rooth_pkg;

    // ----------------------------------------------------------
    // Operation codes
    // ----------------------------------------------------------
    typedef enum logic [`ALU_OP_WIDTH-1:0] {
        ALU_ADD    = 5'd0,
        ALU_SUB    = 5'd1,
        ALU_XOR    = 5'd2,
        ALU_OR     = 5'd3,
        ALU_AND    = 5'd4,
        ALU_SLL    = 5'd5,
        ALU_SRL    = 5'd6,
        ALU_SRA    = 5'd7,
        ALU_SLT    = 5'd8,
        ALU_SLTU   = 5'd9,
        ALU_MUL    = 5'd10,
        ALU_MULH   = 5'd11,
        ALU_MULHU  = 5'd12,
        ALU_MULHSU = 5'd13,
        ALU_DIV    = 5'd14,
        ALU_DIVU   = 5'd15,
        ALU_REM    = 5'd16,
        ALU_REMU   = 5'd17,
        ALU_NOP    = 5'd18
    } alu_op_e;

    // ----------------------------------------------------------
    // Request and result
    // ----------------------------------------------------------
    typedef struct packed {
        alu_op_e                op;
        logic [`CPU_WIDTH-1:0]  src1;
        logic [`CPU_WIDTH-1:0]  src2;
    } exec_req_t;

    // Flags used by branch resolution
    typedef struct packed {
        logic zero;
        logic less;
        logic more_zero;
    } alu_flags_t;

    typedef struct packed {
        logic [`CPU_WIDTH-1:0]  result;
        alu_flags_t             flags;
    } exec_res_t;

endpackage

// ==== logic/alu_core.sv ====
/*
 * ALU core
 * Combinational datapath for every single-cycle operation, plus the
 * request toward the multi-cycle divider for divide and remainder
 */

`timescale 1ns/10ps

`include "rooth_config.svh"

module alu_core (
    input  rooth_pkg::exec_req_t        req_i,
    input  logic                        div_ready_i,
    input  logic [`CPU_WIDTH-1:0]       div_result_i,
    output logic [`CPU_WIDTH-1:0]       dividend_o,
    output logic [`CPU_WIDTH-1:0]       divisor_o,
    output rooth_pkg::alu_op_e          div_op_o,
    output logic                        div_start_o,
    output logic                        done_o,
    output rooth_pkg::exec_res_t        res_o
);

    logic [`CPU_WIDTH-1:0]          src1;
    logic [`CPU_WIDTH-1:0]          src2;
    logic                           src1_neg;
    logic                           src2_neg;
    logic [`CPU_WIDTH-1:0]          src1_inv;
    logic [`CPU_WIDTH-1:0]          src2_inv;
    logic [`SHAMT_WIDTH-1:0]        shamt;
    logic [`CPU_WIDTH-1:0]          sub_res;
    logic [`CPU_DOUBLE_WIDTH-1:0]   sra_ext;
    logic                           slt_res;
    logic                           sltu_res;
    logic [`CPU_WIDTH-1:0]          mul_a;
    logic [`CPU_WIDTH-1:0]          mul_b;
    logic [`CPU_DOUBLE_WIDTH-1:0]   product;
    logic [`CPU_DOUBLE_WIDTH-1:0]   product_inv;

    assign src1     = req_i.src1;
    assign src2     = req_i.src2;
    assign src1_neg = src1[`CPU_WIDTH-1];
    assign src2_neg = src2[`CPU_WIDTH-1];
    assign src1_inv = ~src1 + 1'b1;
    assign src2_inv = ~src2 + 1'b1;
    assign shamt    = src2[`SHAMT_WIDTH-1:0];
    assign sub_res  = src1 - src2;

    // Arithmetic shift through a sign-extended double word
    assign sra_ext  = {{`CPU_WIDTH{src1_neg}}, src1} >> shamt;

    // When the signs differ the negative one is less
    assign slt_res  = (src1_neg != src2_neg) ? src1_neg : (src1 < src2);
    assign sltu_res = (src1 < src2);

    // ----------------------------------------------------------
    // Multiplier over one product of magnitudes
    // ----------------------------------------------------------
    always_comb begin
        mul_a = src1;
        mul_b = src2;
        case (req_i.op)
            rooth_pkg::ALU_MULH: begin
                mul_a = src1_neg ? src1_inv : src1;
                mul_b = src2_neg ? src2_inv : src2;
            end
            rooth_pkg::ALU_MULHSU: begin
                mul_a = src1_neg ? src1_inv : src1;
            end
            default: begin
                mul_a = src1;
                mul_b = src2;
            end
        endcase
    end

    assign product     = {{`CPU_WIDTH{1'b0}}, mul_a} * {{`CPU_WIDTH{1'b0}}, mul_b};
    assign product_inv = ~product + 1'b1;

    // ----------------------------------------------------------
    // Result select and divider request
    // ----------------------------------------------------------
    always_comb begin
        res_o       = '0;
        dividend_o  = '0;
        divisor_o   = '0;
        div_op_o    = rooth_pkg::ALU_NOP;
        div_start_o = 1'b0;
        done_o      = 1'b1;
        case (req_i.op)
            rooth_pkg::ALU_ADD: res_o.result = src1 + src2;
            rooth_pkg::ALU_SUB: begin
                res_o.result     = sub_res;
                res_o.flags.zero = (sub_res == '0);
            end
            rooth_pkg::ALU_XOR: res_o.result = src1 ^ src2;
            rooth_pkg::ALU_OR:  res_o.result = src1 | src2;
            rooth_pkg::ALU_AND: res_o.result = src1 & src2;
            rooth_pkg::ALU_SLL: res_o.result = src1 << shamt;
            rooth_pkg::ALU_SRL: res_o.result = src1 >> shamt;
            rooth_pkg::ALU_SRA: res_o.result = sra_ext[`CPU_WIDTH-1:0];
            rooth_pkg::ALU_SLT: begin
                res_o.result          = {{(`CPU_WIDTH-1){1'b0}}, slt_res};
                res_o.flags.less      = slt_res;
                res_o.flags.more_zero = ~slt_res;
            end
            rooth_pkg::ALU_SLTU: begin
                res_o.result          = {{(`CPU_WIDTH-1){1'b0}}, sltu_res};
                res_o.flags.less      = sltu_res;
                res_o.flags.more_zero = ~sltu_res;
            end
            rooth_pkg::ALU_MUL:   res_o.result = product[`CPU_WIDTH-1:0];
            rooth_pkg::ALU_MULHU: res_o.result = product[`CPU_DOUBLE_WIDTH-1:`CPU_WIDTH];
            rooth_pkg::ALU_MULH: begin
                if (src1_neg ^ src2_neg) begin
                    res_o.result = product_inv[`CPU_DOUBLE_WIDTH-1:`CPU_WIDTH];
                end else begin
                    res_o.result = product[`CPU_DOUBLE_WIDTH-1:`CPU_WIDTH];
                end
            end
            rooth_pkg::ALU_MULHSU: begin
                if (src1_neg) begin
                    res_o.result = product_inv[`CPU_DOUBLE_WIDTH-1:`CPU_WIDTH];
                end else begin
                    res_o.result = product[`CPU_DOUBLE_WIDTH-1:`CPU_WIDTH];
                end
            end
            rooth_pkg::ALU_DIV, rooth_pkg::ALU_DIVU,
            rooth_pkg::ALU_REM, rooth_pkg::ALU_REMU: begin
                // Hold start until the divider answers
                dividend_o = src1;
                divisor_o  = src2;
                div_op_o   = req_i.op;
                if (div_ready_i) begin
                    res_o.result = div_result_i;
                end else begin
                    div_start_o = 1'b1;
                    done_o      = 1'b0;
                end
            end
            default: begin
                // NOP and unused codes finish with a zero result
                res_o = '0;
            end
        endcase
    end

endmodule

// ==== logic/div_unit.sv ====
/*
 * Iterative divider
 * Restoring radix-2 division on operand magnitudes, one bit per cycle,
 * with sign fix-up and quotient or remainder select at the end
 */

`timescale 1ns/10ps

`include "rooth_config.svh"

module div_unit (
    input  logic                    clk_i,
    input  logic                    arst_n_i,
    input  logic                    start_i,
    input  logic [`CPU_WIDTH-1:0]   dividend_i,
    input  logic [`CPU_WIDTH-1:0]   divisor_i,
    input  rooth_pkg::alu_op_e      op_i,
    output logic                    ready_o,
    output logic [`CPU_WIDTH-1:0]   result_o
);

    localparam int CNT_W = $clog2(`CPU_WIDTH);

    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_RUN  = 2'd1,
        ST_DONE = 2'd2
    } div_state_e;

    div_state_e                 state_q;
    logic [CNT_W-1:0]           cnt_q;
    logic                       load;
    logic                       signed_op;
    logic                       a_neg;
    logic                       b_neg;

    // Working registers
    logic [`CPU_WIDTH-1:0]      quo_q;
    logic [`CPU_WIDTH-1:0]      rem_q;
    logic [`CPU_WIDTH-1:0]      divisor_q;
    logic [`CPU_WIDTH-1:0]      dividend_q;
    logic                       neg_quo_q;
    logic                       neg_rem_q;
    logic                       div_zero_q;
    logic                       rem_sel_q;

    logic [`CPU_WIDTH:0]        rem_shift;
    logic [`CPU_WIDTH:0]        trial;
    logic [`CPU_WIDTH-1:0]      quo_fix;
    logic [`CPU_WIDTH-1:0]      rem_fix;

    // Operands load only in idle and start is ignored while running
    assign load      = (state_q == ST_IDLE) && start_i;
    assign signed_op = (op_i == rooth_pkg::ALU_DIV) || (op_i == rooth_pkg::ALU_REM);
    assign a_neg     = signed_op & dividend_i[`CPU_WIDTH-1];
    assign b_neg     = signed_op & divisor_i[`CPU_WIDTH-1];

    // Shift in the next dividend bit and try the subtraction
    assign rem_shift = {rem_q, quo_q[`CPU_WIDTH-1]};
    assign trial     = rem_shift - {1'b0, divisor_q};

    // ----------------------------------------------------------
    // Control FSM
    // ----------------------------------------------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= ST_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (start_i) begin
                        state_q <= ST_RUN;
                        cnt_q   <= '0;
                    end
                end
                ST_RUN: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == CNT_W'(`CPU_WIDTH-1)) begin
                        state_q <= ST_DONE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // ----------------------------------------------------------
    // Datapath
    // ----------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (load) begin
            quo_q      <= a_neg ? (~dividend_i + 1'b1) : dividend_i;
            divisor_q  <= b_neg ? (~divisor_i + 1'b1) : divisor_i;
            rem_q      <= '0;
            dividend_q <= dividend_i;
            neg_quo_q  <= a_neg ^ b_neg;
            neg_rem_q  <= a_neg;
            div_zero_q <= (divisor_i == '0);
            rem_sel_q  <= (op_i == rooth_pkg::ALU_REM) || (op_i == rooth_pkg::ALU_REMU);
        end else if (state_q == ST_RUN) begin
            if (!trial[`CPU_WIDTH]) begin
                rem_q <= trial[`CPU_WIDTH-1:0];
                quo_q <= {quo_q[`CPU_WIDTH-2:0], 1'b1};
            end else begin
                rem_q <= rem_shift[`CPU_WIDTH-1:0];
                quo_q <= {quo_q[`CPU_WIDTH-2:0], 1'b0};
            end
        end
    end

    // MIN / -1 already yields MIN and a zero remainder before the sign fix-up
    always_comb begin
        quo_fix = neg_quo_q ? (~quo_q + 1'b1) : quo_q;
        rem_fix = neg_rem_q ? (~rem_q + 1'b1) : rem_q;
        if (div_zero_q) begin
            quo_fix = '1;
            rem_fix = dividend_q;
        end
    end

    assign result_o = rem_sel_q ? rem_fix : quo_fix;
    assign ready_o  = (state_q == ST_DONE);

endmodule

// ==== logic/exec_unit.sv ====
/*
 * Execute stage top
 * Holds one request, runs it through the ALU core or the divider
 * and registers the result with a one-cycle valid pulse
 */

`timescale 1ns/10ps

`include "rooth_config.svh"

module exec_unit (
    input  logic                    clk_i,
    input  logic                    arst_n_i,
    input  logic                    valid_i,
    input  rooth_pkg::exec_req_t    req_i,
    output logic                    busy_o,
    output logic                    res_valid_o,
    output rooth_pkg::exec_res_t    res_o
);

    rooth_pkg::exec_req_t       req_q;
    logic                       held_q;
    rooth_pkg::exec_req_t       core_req;

    logic [`CPU_WIDTH-1:0]      div_dividend;
    logic [`CPU_WIDTH-1:0]      div_divisor;
    rooth_pkg::alu_op_e         div_op;
    logic                       div_start;
    logic                       div_ready;
    logic [`CPU_WIDTH-1:0]      div_result;
    logic                       core_done;
    rooth_pkg::exec_res_t       core_res;
    logic                       finish;

    // ----------------------------------------------------------
    // Request register
    // ----------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (valid_i && !held_q) begin
            req_q <= req_i;
        end
    end

    // Nothing held looks like a NOP, so the divider never starts idle
    always_comb begin
        core_req = req_q;
        if (!held_q) begin
            core_req.op = rooth_pkg::ALU_NOP;
        end
    end

    assign finish = held_q && core_done;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            held_q <= 1'b0;
        end else if (valid_i && !held_q) begin
            held_q <= 1'b1;
        end else if (finish) begin
            held_q <= 1'b0;
        end
    end

    assign busy_o = held_q;

    alu_core u_alu_core (
        .req_i        (core_req),
        .div_ready_i  (div_ready),
        .div_result_i (div_result),
        .dividend_o   (div_dividend),
        .divisor_o    (div_divisor),
        .div_op_o     (div_op),
        .div_start_o  (div_start),
        .done_o       (core_done),
        .res_o        (core_res)
    );

    div_unit u_div_unit (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .start_i    (div_start),
        .dividend_i (div_dividend),
        .divisor_i  (div_divisor),
        .op_i       (div_op),
        .ready_o    (div_ready),
        .result_o   (div_result)
    );

    // ----------------------------------------------------------
    // Result register
    // ----------------------------------------------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            res_valid_o <= 1'b0;
            res_o       <= '0;
        end else begin
            res_valid_o <= finish;
            if (finish) begin
                res_o <= core_res;
            end
        end
    end

endmodule

// ==== verif/tb_exec_unit.sv ====
/*
 * Testbench for the execute stage
 * Directed corners and random operands against a reference model,
 * with a queue of expected results checked on every result pulse
 */

`timescale 1ns/10ps

`include "rooth_config.svh"

module tb_exec_unit;

    localparam int CLK_PERIOD = 8;
    localparam int N_CORNER   = 5;
    localparam int N_RAND     = 20;
    localparam int N_MIX      = 6;
    localparam int NUM_REQ    = 19 * N_CORNER * N_CORNER + 8 * N_RAND + 2 * N_MIX;
    localparam logic [`CPU_WIDTH-1:0] MIN_VAL = {1'b1, {(`CPU_WIDTH-1){1'b0}}};

    logic                   clk_i;
    logic                   arst_n_i;
    logic                   valid_i;
    rooth_pkg::exec_req_t   req_i;
    logic                   busy_o;
    logic                   res_valid_o;
    rooth_pkg::exec_res_t   res_o;

    rooth_pkg::exec_res_t   exp_q[$];
    rooth_pkg::exec_res_t   exp_res;
    int                     n_checked;
    integer                 seed;

    logic [`CPU_WIDTH-1:0]  corners [N_CORNER] = '{32'h0000_0000, 32'hffff_ffff,
                                                   32'h8000_0000, 32'h7fff_ffff,
                                                   32'h0000_001f};
    rooth_pkg::alu_op_e     md_ops [8] = '{rooth_pkg::ALU_MUL, rooth_pkg::ALU_MULH,
                                           rooth_pkg::ALU_MULHU, rooth_pkg::ALU_MULHSU,
                                           rooth_pkg::ALU_DIV, rooth_pkg::ALU_DIVU,
                                           rooth_pkg::ALU_REM, rooth_pkg::ALU_REMU};

    exec_unit dut (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .valid_i     (valid_i),
        .req_i       (req_i),
        .busy_o      (busy_o),
        .res_valid_o (res_valid_o),
        .res_o       (res_o)
    );

    initial clk_i = 1'b0;
    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // ------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------
    function automatic rooth_pkg::exec_res_t exec_model(input rooth_pkg::exec_req_t req);
        rooth_pkg::exec_res_t           res;
        logic [`CPU_WIDTH-1:0]          a;
        logic [`CPU_WIDTH-1:0]          b;
        logic [`SHAMT_WIDTH-1:0]        sh;
        logic signed [`CPU_DOUBLE_WIDTH-1:0] sa;
        logic signed [`CPU_DOUBLE_WIDTH-1:0] sb;
        logic signed [`CPU_DOUBLE_WIDTH-1:0] ua;
        logic signed [`CPU_DOUBLE_WIDTH-1:0] ub;
        logic [`CPU_DOUBLE_WIDTH-1:0]   prod;
        logic                           ovf;
        res  = '0;
        a    = req.src1;
        b    = req.src2;
        sh   = b[`SHAMT_WIDTH-1:0];
        sa   = $signed(a);
        sb   = $signed(b);
        ua   = {{`CPU_WIDTH{1'b0}}, a};
        ub   = {{`CPU_WIDTH{1'b0}}, b};
        ovf  = (a == MIN_VAL) && (b == '1);
        prod = '0;
        case (req.op)
            rooth_pkg::ALU_ADD: res.result = a + b;
            rooth_pkg::ALU_SUB: begin
                res.result     = a - b;
                res.flags.zero = (a == b);
            end
            rooth_pkg::ALU_XOR: res.result = a ^ b;
            rooth_pkg::ALU_OR:  res.result = a | b;
            rooth_pkg::ALU_AND: res.result = a & b;
            rooth_pkg::ALU_SLL: res.result = a << sh;
            rooth_pkg::ALU_SRL: res.result = a >> sh;
            rooth_pkg::ALU_SRA: res.result = $signed(a) >>> sh;
            rooth_pkg::ALU_SLT, rooth_pkg::ALU_SLTU: begin
                if (req.op == rooth_pkg::ALU_SLT) begin
                    res.result = ($signed(a) < $signed(b)) ? 1 : 0;
                end else begin
                    res.result = (a < b) ? 1 : 0;
                end
                res.flags.less      = res.result[0];
                res.flags.more_zero = !res.result[0];
            end
            rooth_pkg::ALU_MUL: begin
                prod       = ua * ub;
                res.result = prod[`CPU_WIDTH-1:0];
            end
            rooth_pkg::ALU_MULH, rooth_pkg::ALU_MULHU, rooth_pkg::ALU_MULHSU: begin
                if (req.op == rooth_pkg::ALU_MULH) begin
                    prod = sa * sb;
                end else if (req.op == rooth_pkg::ALU_MULHU) begin
                    prod = ua * ub;
                end else begin
                    prod = sa * ub;
                end
                res.result = prod[`CPU_DOUBLE_WIDTH-1:`CPU_WIDTH];
            end
            rooth_pkg::ALU_DIV: begin
                if (b == '0) res.result = '1;
                else if (ovf) res.result = a;
                else res.result = $signed(a) / $signed(b);
            end
            rooth_pkg::ALU_REM: begin
                if (b == '0) res.result = a;
                else if (ovf) res.result = '0;
                else res.result = $signed(a) % $signed(b);
            end
            rooth_pkg::ALU_DIVU: res.result = (b == '0) ? '1 : a / b;
            rooth_pkg::ALU_REMU: res.result = (b == '0) ? a : a % b;
            default: res = '0;
        endcase
        return res;
    endfunction

    task automatic check_val(input logic [63:0] got, input logic [63:0] expected,
                             input string what);
        if (got !== expected) begin
            $display("[ERROR] %0t ns: %s mismatch, got %0h expected %0h",
                     $time, what, got, expected);
            $display("Some tests failed");
            $fatal(1, "value check failed");
        end
    endtask

    // One request plus an optional valid pulse while busy that must be dropped
    task automatic issue_req(input rooth_pkg::alu_op_e op, input logic [`CPU_WIDTH-1:0] a,
                             input logic [`CPU_WIDTH-1:0] b, input logic extra);
        rooth_pkg::exec_req_t req;
        req.op   = op;
        req.src1 = a;
        req.src2 = b;
        exp_q.push_back(exec_model(req));
        valid_i = 1'b1;
        req_i   = req;
        @(posedge clk_i);
        #1;
        valid_i = 1'b0;
        if (extra) begin
            valid_i    = 1'b1;
            req_i.op   = rooth_pkg::ALU_ADD;
            req_i.src1 = ~a;
            req_i.src2 = ~b;
            @(posedge clk_i);
            #1;
            valid_i = 1'b0;
        end
        while (busy_o) begin
            @(posedge clk_i);
            #1;
        end
    endtask

    // ------------------------------------------------------------
    // Compare process on the falling edge where results are stable
    // ------------------------------------------------------------
    always @(negedge clk_i) begin
        if (res_valid_o) begin
            if (exp_q.size() == 0) begin
                $display("The DUT gave a result at %0t ns with no request pending", $time);
                $display("Some tests failed");
                $fatal(1, "unexpected result");
            end else begin
                exp_res = exp_q.pop_front();
                check_val(res_o.result, exp_res.result, $sformatf("result #%0d", n_checked));
                check_val(res_o.flags, exp_res.flags, $sformatf("flags #%0d", n_checked));
                n_checked++;
            end
        end
    end

    // Watchdog
    initial begin
        #((NUM_REQ * (`CPU_WIDTH + 8) + 200) * CLK_PERIOD);
        $display("The DUT hung: the tests did not finish in time");
        $display("Some tests failed");
        $fatal(1, "timeout");
    end

    // ------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------
    initial begin
        logic [`CPU_WIDTH-1:0] a;
        logic [`CPU_WIDTH-1:0] b;
        seed      = 32'h0e5a_ef31;
        n_checked = 0;
        arst_n_i  = 1'b0;
        valid_i   = 1'b0;
        req_i     = '0;
        repeat (2) @(posedge clk_i);
        #1;
        arst_n_i = 1'b1;

        // Idle after reset
        repeat (3) begin
            check_val(busy_o, 1'b0, "busy after reset");
            check_val(res_valid_o, 1'b0, "valid after reset");
            check_val(res_o, '0, "result after reset");
            @(posedge clk_i);
            #1;
        end

        // Every operation over the corner values
        for (int k = 0; k < 19; k++) begin
            for (int i = 0; i < N_CORNER; i++) begin
                for (int j = 0; j < N_CORNER; j++) begin
                    issue_req(rooth_pkg::alu_op_e'(k), corners[i], corners[j], 1'b0);
                end
            end
        end

        // Random multiply and divide with some small divisors
        for (int i = 0; i < N_RAND; i++) begin
            for (int k = 0; k < 8; k++) begin
                a = $random(seed);
                b = $random(seed);
                if (i % 4 == 0) begin
                    b = {{(`CPU_WIDTH-4){b[`CPU_WIDTH-1]}}, b[3:0]};
                end
                issue_req(md_ops[k], a, b, 1'b0);
            end
        end

        // Division followed at once by a single-cycle operation
        for (int i = 0; i < N_MIX; i++) begin
            a = $random(seed);
            b = $random(seed);
            issue_req(md_ops[4 + (i % 4)], a, b, 1'b1);
            issue_req(rooth_pkg::alu_op_e'(i), b, a, 1'b0);
        end

        repeat (4) @(posedge clk_i);
        if (exp_q.size() != 0) begin
            $display("[ERROR] %0t ns: %0d results never arrived", $time, exp_q.size());
            $display("Some tests failed");
            $fatal(1, "missing results");
        end else begin
            $display("All tests passed");
            $finish;
        end
    end

endmodule

// ==== list.f ====
+incdir+logic
logic/rooth_pkg.sv
logic/alu_core.sv
logic/div_unit.sv
logic/exec_unit.sv
verif/tb_exec_unit.sv
